// ==== processor_core.f ====
design/rv_core_pkg.sv
design/core_intf.sv
design/ifu.sv
design/idu.sv
design/gpr.sv
design/alu.sv
design/exu.sv
design/processor_core.sv
verification/processor_core_tb.sv

// ==== Bender.yml ====
package:
  name: processor_core

sources:
  - files:
      - design/rv_core_pkg.sv
      - design/core_intf.sv
      - design/ifu.sv
      - design/idu.sv
      - design/gpr.sv
      - design/alu.sv
      - design/exu.sv
      - design/processor_core.sv
  - target: simulation
    files:
      - verification/processor_core_tb.sv

// ==== verification/processor_core_tb.sv ====
module processor_core_tb
    import rv_core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    NUM_PROGS   = 20;
    localparam int    PROG_LEN    = 64;
    localparam int    DATA_WORDS  = 256;
    localparam int    CYCLE_LIMIT = NUM_PROGS * (PROG_LEN + 8);
    localparam word_t DATA_BASE   = 32'h0001_0000;
    localparam word_t EBREAK_WORD = 32'h0010_0073;

    localparam logic [6:0] ENC_LUI    = 7'b0110111;
    localparam logic [6:0] ENC_AUIPC  = 7'b0010111;
    localparam logic [6:0] ENC_JAL    = 7'b1101111;
    localparam logic [6:0] ENC_JALR   = 7'b1100111;
    localparam logic [6:0] ENC_BRANCH = 7'b1100011;
    localparam logic [6:0] ENC_LOAD   = 7'b0000011;
    localparam logic [6:0] ENC_STORE  = 7'b0100011;
    localparam logic [6:0] ENC_OP_IMM = 7'b0010011;
    localparam logic [6:0] ENC_OP     = 7'b0110011;
    localparam logic [6:0] ENC_SYSTEM = 7'b1110011;

    // sw x0, 0(x0) addresses nothing inside the data window.
    localparam word_t STORE_X0_WORD = {7'b0, 5'd0, 5'd0, 3'b010, 5'd0, ENC_STORE};

    logic  clk = 1'b0;
    logic  rst_n;
    word_t imem_addr;
    word_t imem_rdata;
    word_t dmem_addr;
    word_t dmem_rdata;
    word_t dmem_wdata;
    logic  dmem_wen;
    logic  halt;
    logic  trap;
    word_t halt_value;

    word_t prog [PROG_LEN];
    word_t dmem [DATA_WORDS];
    word_t model_mem [DATA_WORDS];
    word_t mregs [32];
    word_t mpc;
    word_t imem_index;
    word_t dmem_index;
    int    cur_prog = 0;
    int    value_errors = 0;
    int    other_errors = 0;
    int    cycles = 0;

    processor_core processor_core_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_rdata (dmem_rdata),
        .dmem_wdata (dmem_wdata),
        .dmem_wen   (dmem_wen),
        .halt       (halt),
        .trap       (trap),
        .halt_value (halt_value)
    );

    always #50 clk = ~clk;

    // both memories answer in the same cycle; addresses outside them read a pattern.
    assign imem_index = (imem_addr - RESET_PC) >> 2;
    assign imem_rdata = (imem_index < PROG_LEN) ? prog[imem_index[5:0]] : ~imem_addr;
    assign dmem_index = (dmem_addr - DATA_BASE) >> 2;
    assign dmem_rdata = (dmem_index < DATA_WORDS) ? dmem[dmem_index[7:0]]
                                                   : (dmem_addr ^ 32'h5a5a_a5a5);

    always @(posedge clk)
    begin
        if (dmem_wen && (dmem_index < DATA_WORDS))
        begin
            dmem[dmem_index[7:0]] <= dmem_wdata;
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        value_errors++;
        $display("[ERROR] %s, program %0d: expected %h, actual %h",
                 name, cur_prog, expected, actual);
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("program %0d: %s", cur_prog, what);
    endtask

    function automatic word_t window_index(input word_t addr);
        return (addr - DATA_BASE) >> 2;
    endfunction

    function automatic logic [4:0] pick_rd();
        return ($urandom % 4 == 0) ? 5'd0 : 5'($urandom % 29 + 1);
    endfunction

    function automatic logic [4:0] pick_src();
        return ($urandom % 4 == 0) ? 5'd0 : 5'($urandom % 32);
    endfunction

    function automatic logic [2:0] funct3_of(input op_e op);
        case (op)
            OP_BNE, OP_SLLI, OP_SLL:                 return 3'b001;
            OP_LW, OP_SW, OP_SLTI, OP_SLT:           return 3'b010;
            OP_SLTIU, OP_SLTU:                       return 3'b011;
            OP_BLT, OP_XORI, OP_XOR:                 return 3'b100;
            OP_BGE, OP_SRLI, OP_SRAI, OP_SRL, OP_SRA: return 3'b101;
            OP_BLTU, OP_ORI, OP_OR:                  return 3'b110;
            OP_BGEU, OP_ANDI, OP_AND:                return 3'b111;
            default:                                 return 3'b000;
        endcase
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic [6:0] f7,
                                      input word_t a, input word_t b, input logic imm_form);
        logic alt;
        alt = (f7 == 7'b0100000);
        case (f3)
            3'b000:  return (alt && !imm_form) ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // slots are filled from the end, so every jump target is already known.
    task automatic build_program(input int p);
        int         i;
        int         t;
        op_e        op;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      imm;
        word_t      off;
        word_t      doff;
        word_t      tgt;
        word_t      hi;
        logic       blocked [PROG_LEN];
        for (int k = 0; k < PROG_LEN; k++)
        begin
            blocked[k] = 1'b0;
        end
        prog[0] = {DATA_BASE[31:12], 5'd31, ENC_LUI};
        prog[PROG_LEN - 1] = EBREAK_WORD;
        if (p % 7 == 3)
        begin
            // low opcode bits other than 2'b11 never belong to the base set.
            prog[PROG_LEN - 1] = $urandom;
            prog[PROG_LEN - 1][1:0] = 2'($urandom % 3);
        end
        i = PROG_LEN - 2;
        while (i > 0)
        begin
            op = op_e'($urandom % 31);
            if (op == OP_JALR && i < 3)
                op = OP_ADDI;
            rd   = pick_rd();
            rs1  = pick_src();
            rs2  = pick_src();
            f3   = funct3_of(op);
            f7   = (op inside {OP_SUB, OP_SRA, OP_SRAI}) ? 7'b0100000 : 7'b0000000;
            imm  = $urandom;
            doff = ($urandom % DATA_WORDS) * 4;
            t    = i + 1 + ($urandom % (PROG_LEN - 1 - i));
            while (blocked[t])
                t++;
            off = (t - i) * 4;
            case (op)
                OP_LUI:   prog[i] = {imm[31:12], rd, ENC_LUI};
                OP_AUIPC: prog[i] = {imm[31:12], rd, ENC_AUIPC};
                OP_JAL:   prog[i] = {off[20], off[10:1], off[11], off[19:12], rd, ENC_JAL};
                OP_JALR:
                begin
                    // x30 gets the absolute target, and an odd offset tests bit 0 clearing.
                    tgt = RESET_PC + 4 * t;
                    hi  = (tgt + 32'h800) >> 12;
                    prog[i - 2] = {hi[19:0], 5'd30, ENC_LUI};
                    prog[i - 1] = {tgt[11:0], 5'd30, 3'b000, 5'd30, ENC_OP_IMM};
                    prog[i]     = {11'b0, imm[0], 5'd30, 3'b000, rd, ENC_JALR};
                    blocked[i - 1] = 1'b1;
                    blocked[i]     = 1'b1;
                    i = i - 2;
                end
                OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
                    prog[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], ENC_BRANCH};
                OP_LW:    prog[i] = {doff[11:0], 5'd31, f3, rd, ENC_LOAD};
                OP_SW:    prog[i] = {doff[11:5], rs2, 5'd31, f3, doff[4:0], ENC_STORE};
                OP_SLLI, OP_SRLI, OP_SRAI:
                    prog[i] = {f7, imm[4:0], rs1, f3, rd, ENC_OP_IMM};
                OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI:
                    prog[i] = {imm[11:0], rs1, f3, rd, ENC_OP_IMM};
                default:  prog[i] = {f7, rs2, rs1, f3, rd, ENC_OP};
            endcase
            i = i - 1;
        end
    endtask

    // executes one instruction on the architectural copy and checks the data port.
    task automatic model_step(input word_t inst, output int stop);
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      addr;
        word_t      res;
        word_t      npc;
        logic       valid;
        logic       wr;
        logic       store;
        logic       taken;
        f3    = inst[14:12];
        f7    = inst[31:25];
        a     = mregs[inst[19:15]];
        b     = mregs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        addr  = '0;
        npc   = mpc + 4;
        res   = mpc + 4;
        valid = 1'b1;
        wr    = 1'b0;
        store = 1'b0;
        taken = 1'b0;
        stop  = 0;
        case (inst[6:0])
            ENC_LUI:
            begin
                res = {inst[31:12], 12'b0};
                wr  = 1'b1;
            end
            ENC_AUIPC:
            begin
                res = mpc + {inst[31:12], 12'b0};
                wr  = 1'b1;
            end
            ENC_JAL:
            begin
                npc = mpc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                wr  = 1'b1;
            end
            ENC_JALR:
            begin
                npc   = (a + imm_i) & ~32'h1;
                wr    = 1'b1;
                valid = (f3 == 3'b000);
            end
            ENC_BRANCH:
            begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: valid = 1'b0;
                endcase
                if (taken)
                    npc = mpc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            ENC_LOAD:
            begin
                addr  = a + imm_i;
                wr    = 1'b1;
                valid = (f3 == 3'b010);
                if (window_index(addr) < DATA_WORDS)
                    res = model_mem[window_index(addr)];
                else
                    report_failure("a load address fell outside the data window");
            end
            ENC_STORE:
            begin
                addr  = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                store = 1'b1;
                valid = (f3 == 3'b010);
            end
            ENC_OP_IMM:
            begin
                res   = alu_ref(f3, f7, a, imm_i, 1'b1);
                wr    = 1'b1;
                valid = (f3 != 3'b001 && f3 != 3'b101) || (f7 == 7'b0000000)
                        || (f3 == 3'b101 && f7 == 7'b0100000);
            end
            ENC_OP:
            begin
                res   = alu_ref(f3, f7, a, b, 1'b0);
                wr    = 1'b1;
                valid = (f7 == 7'b0000000)
                        || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
            end
            ENC_SYSTEM:
            begin
                if (inst == EBREAK_WORD)
                    stop = 1;
                else
                    valid = 1'b0;
            end
            default: valid = 1'b0;
        endcase
        if (stop == 0 && !valid)
            stop = 2;
        if (store && valid)
        begin
            if (dmem_wen !== 1'b1)
                report_mismatch("store enable", 32'd1, dmem_wen);
            if (dmem_addr !== addr)
                report_mismatch("store address", addr, dmem_addr);
            if (dmem_wdata !== b)
                report_mismatch("store data", b, dmem_wdata);
            if (window_index(addr) < DATA_WORDS)
                model_mem[window_index(addr)] = b;
            else
                report_failure("a store address fell outside the data window");
        end
        else if (dmem_wen !== 1'b0)
            report_mismatch("store enable", 32'd0, dmem_wen);
        if (stop == 0)
        begin
            if (wr && inst[11:7] != 5'd0)
                mregs[inst[11:7]] = res;
            mpc = npc;
        end
    endtask

    // called at 1 ns after a rising edge and returns at the same point of a later cycle.
    task automatic run_program(input int p);
        int    stop;
        int    steps;
        word_t stop_pc;
        word_t w;
        word_t entry_word;
        cur_prog = p;
        rst_n    = 1'b0;
        build_program(p);
        // a store sits at the reset address while reset is held.
        entry_word = prog[0];
        prog[0]    = STORE_X0_WORD;
        for (int k = 0; k < DATA_WORDS; k++)
        begin
            w            = $urandom;
            dmem[k]      = w;
            model_mem[k] = w;
        end
        for (int k = 0; k < 32; k++)
        begin
            mregs[k] = '0;
        end
        mpc = RESET_PC;
        repeat (2)
        begin
            @(posedge clk);
            #98;
            if (imem_addr !== RESET_PC)
                report_mismatch("reset pc", RESET_PC, imem_addr);
            if (dmem_wen !== 1'b0)
                report_mismatch("reset dmem_wen", 32'd0, dmem_wen);
            if (halt !== 1'b0)
                report_mismatch("reset halt", 32'd0, halt);
            if (trap !== 1'b0)
                report_mismatch("reset trap", 32'd0, trap);
        end
        @(posedge clk);
        #1;
        rst_n   = 1'b1;
        prog[0] = entry_word;
        stop    = 0;
        steps   = 0;
        stop_pc = mpc;
        while (stop == 0 && steps < PROG_LEN)
        begin
            #98;
            if (imem_addr !== mpc)
                report_mismatch("instruction flow", mpc, imem_addr);
            if (halt !== 1'b0 || trap !== 1'b0)
                report_failure("the core stopped before the last instruction");
            stop_pc = mpc;
            model_step(prog[(mpc - RESET_PC) >> 2], stop);
            steps++;
            @(posedge clk);
            #1;
        end
        if (stop == 0)
            report_failure("the reference model ran past the end of the program");
        // a stopped core must neither move nor store, whatever word it fetches.
        prog[(stop_pc - RESET_PC) >> 2] = STORE_X0_WORD;
        repeat (3)
        begin
            #98;
            if (imem_addr !== stop_pc)
                report_mismatch("stopped pc", stop_pc, imem_addr);
            if (dmem_wen !== 1'b0)
                report_mismatch("stopped dmem_wen", 32'd0, dmem_wen);
            if (stop == 1)
            begin
                if (halt !== 1'b1)
                    report_mismatch("ebreak halt", 32'd1, halt);
                if (trap !== 1'b0)
                    report_mismatch("ebreak trap", 32'd0, trap);
                if (halt_value !== mregs[HALT_REG])
                    report_mismatch("ebreak halt_value", mregs[HALT_REG], halt_value);
            end
            else
            begin
                if (trap !== 1'b1)
                    report_mismatch("invalid trap", 32'd1, trap);
                if (halt !== 1'b0)
                    report_mismatch("invalid halt", 32'd0, halt);
            end
            @(posedge clk);
            #1;
        end
    endtask

    initial
    begin
        rst_n = 1'b0;
        for (int k = 0; k < PROG_LEN; k++)
        begin
            prog[k] = EBREAK_WORD;
        end
        for (int k = 0; k < DATA_WORDS; k++)
        begin
            dmem[k] = '0;
        end
        void'($urandom(32'h69e));
        @(posedge clk);
        #1;
        for (int p = 0; p < NUM_PROGS; p++)
        begin
            run_program(p);
        end
        $display("programs: %0d, value errors: %0d, other errors: %0d",
                 NUM_PROGS, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== design/processor_core.sv ====
module processor_core
    import rv_core_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    output word_t imem_addr,
    input  word_t imem_rdata,
    output word_t dmem_addr,
    input  word_t dmem_rdata,
    output word_t dmem_wdata,
    output logic  dmem_wen,
    output logic  halt,
    output logic  trap,
    output word_t halt_value
);

    word_t pc;
    word_t next_pc;
    logic  pc_w_en;
    word_t inst;
    word_t src1;
    word_t src2;
    word_t wdata;
    logic  w_en;

    decode_if dec_bus ();
    alu_if    alu_bus ();

    ifu ifu_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .next_pc    (next_pc),
        .pc_w_en    (pc_w_en),
        .imem_rdata (imem_rdata),
        .pc         (pc),
        .imem_addr  (imem_addr),
        .inst       (inst)
    );

    idu idu_i (
        .inst (inst),
        .dec  (dec_bus)
    );

    gpr gpr_i (
        .clk   (clk),
        .rst_n (rst_n),
        .dec   (dec_bus),
        .wdata (wdata),
        .w_en  (w_en),
        .src1  (src1),
        .src2  (src2)
    );

    alu alu_i (
        .alu (alu_bus)
    );

    exu exu_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec        (dec_bus),
        .pc         (pc),
        .src1       (src1),
        .src2       (src2),
        .alu        (alu_bus),
        .next_pc    (next_pc),
        .pc_w_en    (pc_w_en),
        .wdata      (wdata),
        .w_en       (w_en),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wen   (dmem_wen),
        .dmem_rdata (dmem_rdata),
        .halt       (halt),
        .trap       (trap),
        .halt_value (halt_value)
    );

endmodule

// ==== design/exu.sv ====
module exu
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    decode_if.execute dec,
    input  word_t     pc,
    input  word_t     src1,
    input  word_t     src2,
    alu_if.requester  alu,
    output word_t     next_pc,
    output logic      pc_w_en,
    output word_t     wdata,
    output logic      w_en,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    output logic      dmem_wen,
    input  word_t     dmem_rdata,
    output logic      halt,
    output logic      trap,
    output word_t     halt_value
);

    logic      halt_q;
    logic      trap_q;
    word_t     halt_value_q;
    logic      commit;
    logic      stop;
    logic      is_reg_op;
    logic      writes_rd;
    logic      taken;
    word_t     pc_plus4;
    word_t     pc_plus_imm;
    word_t     jalr_target;
    alu_func_e func;

    assign commit    = !halt_q && !trap_q;
    assign stop      = (dec.op == OP_EBREAK) || (dec.op == OP_INVALID);
    assign is_reg_op = dec.op inside {OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
                                      OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND};
    assign writes_rd = !(dec.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU,
                                        OP_BGEU, OP_SW, OP_EBREAK, OP_INVALID});

    always_comb
    begin
        case (dec.op)
            OP_LUI:            func = ALU_PASS_B;
            OP_SUB:            func = ALU_SUB;
            OP_SLL, OP_SLLI:   func = ALU_SLL;
            OP_SLT, OP_SLTI:   func = ALU_SLT;
            OP_SLTU, OP_SLTIU: func = ALU_SLTU;
            OP_XOR, OP_XORI:   func = ALU_XOR;
            OP_SRL, OP_SRLI:   func = ALU_SRL;
            OP_SRA, OP_SRAI:   func = ALU_SRA;
            OP_OR, OP_ORI:     func = ALU_OR;
            OP_AND, OP_ANDI:   func = ALU_AND;
            // addresses for loads, stores and jalr come out of the adder too.
            default:           func = ALU_ADD;
        endcase
    end

    assign alu.a    = (dec.op == OP_AUIPC) ? pc : src1;
    assign alu.b    = is_reg_op ? src2 : dec.imm;
    assign alu.func = func;

    always_comb
    begin
        case (dec.op)
            OP_BEQ:  taken = (src1 == src2);
            OP_BNE:  taken = (src1 != src2);
            OP_BLT:  taken = ($signed(src1) < $signed(src2));
            OP_BGE:  taken = ($signed(src1) >= $signed(src2));
            OP_BLTU: taken = (src1 < src2);
            OP_BGEU: taken = (src1 >= src2);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4    = pc + 32'd4;
    assign pc_plus_imm = pc + dec.imm;
    assign jalr_target = {alu.result[31:1], 1'b0};

    always_comb
    begin
        if ((dec.op == OP_JAL) || taken)
            next_pc = pc_plus_imm;
        else if (dec.op == OP_JALR)
            next_pc = jalr_target;
        else
            next_pc = pc_plus4;
    end

    always_comb
    begin
        if ((dec.op == OP_JAL) || (dec.op == OP_JALR))
            wdata = pc_plus4;
        else if (dec.op == OP_LW)
            wdata = dmem_rdata;
        else
            wdata = alu.result;
    end

    // a stopping instruction leaves the pc on itself.
    assign pc_w_en = commit && !stop;
    assign w_en    = commit && writes_rd && (dec.rd != '0);

    assign dmem_addr  = alu.result;
    assign dmem_wdata = src2;
    // the data memory is not reset with the core, so no store may reach it while reset is held.
    assign dmem_wen   = rst_n && commit && (dec.op == OP_SW);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            halt_q <= 1'b0;
            trap_q <= 1'b0;
        end
        else if (commit)
        begin
            if (dec.op == OP_EBREAK)
                halt_q <= 1'b1;
            if (dec.op == OP_INVALID)
                trap_q <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst_n && commit && (dec.op == OP_EBREAK))
            halt_value_q <= src1;
    end

    assign halt       = halt_q;
    assign trap       = trap_q;
    assign halt_value = halt_value_q;

endmodule

// ==== design/alu.sv ====
module alu
    import rv_core_pkg::*;
(
    alu_if.unit alu
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = alu.b[4:0];
    assign lt_signed   = $signed(alu.a) < $signed(alu.b);
    assign lt_unsigned = alu.a < alu.b;

    always_comb
    begin
        case (alu.func)
            ALU_ADD:    alu.result = alu.a + alu.b;
            ALU_SUB:    alu.result = alu.a - alu.b;
            ALU_SLL:    alu.result = alu.a << shamt;
            ALU_SLT:    alu.result = {31'b0, lt_signed};
            ALU_SLTU:   alu.result = {31'b0, lt_unsigned};
            ALU_XOR:    alu.result = alu.a ^ alu.b;
            ALU_SRL:    alu.result = alu.a >> shamt;
            ALU_SRA:    alu.result = word_t'($signed(alu.a) >>> shamt);
            ALU_OR:     alu.result = alu.a | alu.b;
            ALU_AND:    alu.result = alu.a & alu.b;
            ALU_PASS_B: alu.result = alu.b;
            default:    alu.result = '0;
        endcase
    end

endmodule

// ==== design/gpr.sv ====
module gpr
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    decode_if.regfile dec,
    input  word_t     wdata,
    input  logic      w_en,
    output word_t     src1,
    output word_t     src2
);

    word_t rf [32];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
            begin
                rf[i] <= '0;
            end
        end
        else if (w_en && (dec.rd != '0))
        begin
            rf[dec.rd] <= wdata;
        end
    end

    // x0 reads as zero whatever the array holds.
    assign src1 = (dec.rs1 == '0) ? '0 : rf[dec.rs1];
    assign src2 = (dec.rs2 == '0) ? '0 : rf[dec.rs2];

endmodule

// ==== design/idu.sv ====
module idu
    import rv_core_pkg::*;
(
    input word_t      inst,
    decode_if.decoder dec
);

    opcode_t    opcode;
    logic [2:0] funct3;
    funct7_t    funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    op_e        op;
    word_t      imm;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb
    begin
        op  = OP_INVALID;
        imm = imm_i;
        case (opcode)
            OPC_LUI:
            begin
                op  = OP_LUI;
                imm = imm_u;
            end
            OPC_AUIPC:
            begin
                op  = OP_AUIPC;
                imm = imm_u;
            end
            OPC_JAL:
            begin
                op  = OP_JAL;
                imm = imm_j;
            end
            OPC_JALR:
            begin
                if (funct3 == 3'b000)
                    op = OP_JALR;
            end
            OPC_BRANCH:
            begin
                imm = imm_b;
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_INVALID;
                endcase
            end
            OPC_LOAD:
            begin
                if (funct3 == 3'b010)
                    op = OP_LW;
            end
            OPC_STORE:
            begin
                imm = imm_s;
                if (funct3 == 3'b010)
                    op = OP_SW;
            end
            OPC_OP_IMM:
            begin
                case (funct3)
                    3'b000: op = OP_ADDI;
                    3'b010: op = OP_SLTI;
                    3'b011: op = OP_SLTIU;
                    3'b100: op = OP_XORI;
                    3'b110: op = OP_ORI;
                    3'b111: op = OP_ANDI;
                    // shift amounts fit in five bits, so the upper field is an encoding.
                    3'b001: op = (funct7 == F7_BASE) ? OP_SLLI : OP_INVALID;
                    3'b101:
                    begin
                        if (funct7 == F7_BASE)
                            op = OP_SRLI;
                        else if (funct7 == F7_ALT)
                            op = OP_SRAI;
                    end
                    default: op = OP_INVALID;
                endcase
            end
            OPC_OP:
            begin
                if (funct7 == F7_BASE)
                begin
                    case (funct3)
                        3'b000: op = OP_ADD;
                        3'b001: op = OP_SLL;
                        3'b010: op = OP_SLT;
                        3'b011: op = OP_SLTU;
                        3'b100: op = OP_XOR;
                        3'b101: op = OP_SRL;
                        3'b110: op = OP_OR;
                        3'b111: op = OP_AND;
                        default: op = OP_INVALID;
                    endcase
                end
                else if (funct7 == F7_ALT)
                begin
                    if (funct3 == 3'b000)
                        op = OP_SUB;
                    else if (funct3 == 3'b101)
                        op = OP_SRA;
                end
            end
            OPC_SYSTEM:
            begin
                if (inst == INST_EBREAK)
                    op = OP_EBREAK;
            end
            default: op = OP_INVALID;
        endcase
    end

    assign dec.op  = op;
    assign dec.imm = imm;
    assign dec.rd  = inst[11:7];
    assign dec.rs2 = inst[24:20];

    // ebreak reports a0, so it is routed to the first read port.
    assign dec.rs1 = (op == OP_EBREAK) ? HALT_REG : inst[19:15];

endmodule

// ==== design/ifu.sv ====
module ifu
    import rv_core_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  word_t next_pc,
    input  logic  pc_w_en,
    input  word_t imem_rdata,
    output word_t pc,
    output word_t imem_addr,
    output word_t inst
);

    word_t pc_q;

    // the pc only moves when execute lets the instruction retire.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc_q <= RESET_PC;
        end
        else if (pc_w_en)
        begin
            pc_q <= next_pc;
        end
    end

    assign pc        = pc_q;
    assign imem_addr = pc_q;

    // instruction memory answers in the same cycle.
    assign inst = imem_rdata;

endmodule

// ==== design/core_intf.sv ====
interface decode_if
    import rv_core_pkg::*;
();

    op_e       op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;

    modport decoder (output op, output rd, output rs1, output rs2, output imm);
    modport execute (input op, input imm, input rd);
    modport regfile (input rs1, input rs2, input rd);

endinterface

interface alu_if
    import rv_core_pkg::*;
();

    word_t     a;
    word_t     b;
    alu_func_e func;
    word_t     result;

    modport requester (output a, output b, output func, input result);
    modport unit (input a, input b, input func, output result);

endinterface

// ==== design/rv_core_pkg.sv ====
package rv_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [6:0]  funct7_t;

    // one value per supported instruction.
    typedef enum logic [5:0] {
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_LW,
        OP_SW,
        OP_ADDI,
        OP_SLTI,
        OP_SLTIU,
        OP_XORI,
        OP_ORI,
        OP_ANDI,
        OP_SLLI,
        OP_SRLI,
        OP_SRAI,
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_EBREAK,
        OP_INVALID
    } op_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_func_e;

    localparam word_t     RESET_PC    = 32'h8000_0000;
    localparam reg_addr_t HALT_REG    = 5'd10;
    localparam word_t     INST_EBREAK = 32'h0010_0073;

    // major opcodes of the base instruction set.
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

endpackage
